// File: common/tg_timing_pkg.sv
`default_nettype none

package tg_timing_pkg;

   // --------------------------------------------------
   // Burst timing words
   // --------------------------------------------------
   typedef logic [14:0] tick_t;   // 0.1 us ticks: delay, width, period, offset
   typedef logic [11:0] count_t;  // Pulse or skip count

   // Burst FSM
   typedef enum logic [3:0] {
      Idle          = 4'd0,
      Armed         = 4'd1,
      BurstStart    = 4'd2,  // Parameters latched, burst_start out
      PulseOffStart = 4'd3,  // Timer load settles
      PulseOff      = 4'd4,  // Delay or gap running
      PulseOnStart  = 4'd5,
      PulseOn       = 4'd6,  // Gate high
      BurstEnd      = 4'd7   // tdone, then re-arm or idle
   } tg_state_e;

   // --------------------------------------------------
   // Prescaler, 10 clocks per tick at 100 MHz
   // --------------------------------------------------
   localparam logic [3:0] PRESCALE_RELOAD = 4'd9;
   localparam logic [3:0] PRESCALE_FIRST  = 4'd7;  // Shortened first tick after load

endpackage

`default_nettype wire

// File: common/tg_meas_pkg.sv
`default_nettype none

package tg_meas_pkg;

   // Measurement scheduling FSM
   typedef enum logic [2:0] {
      MIdle       = 3'd0,
      MArmed      = 3'd1,
      MBurstStart = 3'd2,
      ConvForce   = 3'd3,  // Single forced conversion
      ConvWait    = 3'd4,  // Counting skipped pulses
      ConvDelay   = 3'd5,
      ConvStart   = 3'd6,  // Offset timer running
      ConvEnd     = 3'd7
   } meas_state_e;

   // Serial ADC FSM
   typedef enum logic [2:0] {
      AIdle     = 3'd0,
      SckOn     = 3'd1,
      SckOnWait = 3'd2,
      SckOff    = 3'd3,  // Falling step, SDO sampled here
      Unload    = 3'd4
   } adc_state_e;

   typedef logic [15:0] sample_t;   // Queue word
   typedef logic [10:0] maxcnt_t;   // Global conversion limit

   localparam int          ADC_BITS    = 35;  // SCK cycles per frame
   localparam int          SCK_STRETCH = 2;   // Extra high cycles after SckOn, minus one
   localparam int unsigned FORCE_DELAY = 4;   // Ticks before a forced conversion

endpackage

`default_nettype wire

// File: verilog/tg_ctrl_decode.sv
`timescale 1ns/1ps
`default_nettype none

module tg_ctrl_decode (
   input  logic       clk,
   input  logic       mrst,
   input  logic [7:0] control_i,   // rst, abt, arm, trig, meas_en, src_en, cont, ch_en
   input  logic       t_rst_i,
   input  logic       t_abt_i,
   input  logic       t_arm_i,
   input  logic       t_trig_i,
   input  logic       m_rst_i,
   input  logic       m_abt_i,
   input  logic       m_arm_i,
   input  logic       conv_i,
   output logic       t_clr_o,
   output logic       t_abt_o,
   output logic       t_arm_o,
   output logic       t_trig_rise_o,
   output logic       t_cont_o,
   output logic       src_en_o,
   output logic       m_clr_o,
   output logic       m_abt_o,
   output logic       m_arm_o,
   output logic       m_conv_req_o,
   output logic       q_clr_o
);
   logic trig_q;    // Merged trigger level
   logic trig_dly;  // For edge detect

   always_ff @(posedge clk) begin
      if (mrst) begin
         t_clr_o      <= 1'b1;  // Hold everything cleared
         m_clr_o      <= 1'b1;
         q_clr_o      <= 1'b1;
         t_abt_o      <= 1'b0;
         t_arm_o      <= 1'b0;
         trig_q       <= 1'b0;
         trig_dly     <= 1'b0;
         t_cont_o     <= 1'b0;
         src_en_o     <= 1'b0;
         m_abt_o      <= 1'b0;
         m_arm_o      <= 1'b0;
         m_conv_req_o <= 1'b0;
      end else begin
         // Channel side, a disabled channel acts as a held reset
         t_clr_o  <= control_i[7] | t_rst_i | ~control_i[0];
         t_abt_o  <= control_i[6] | t_abt_i;
         t_arm_o  <= control_i[5] | t_arm_i;
         trig_q   <= control_i[4] | t_trig_i;
         trig_dly <= trig_q;
         t_cont_o <= control_i[1];
         src_en_o <= control_i[2];
         // Measurement side also needs meas enable
         m_clr_o      <= control_i[7] | m_rst_i | ~control_i[3] | ~control_i[0];
         m_abt_o      <= control_i[6] | m_abt_i;
         m_arm_o      <= control_i[5] | m_arm_i;
         m_conv_req_o <= conv_i;
         q_clr_o      <= control_i[7] | m_rst_i;  // Hard resets only, queue survives disable
      end
   end

   assign t_trig_rise_o = trig_q & ~trig_dly;  // One cycle on rising edge

endmodule

`default_nettype wire

// File: verilog/tick_timer.sv
`timescale 1ns/1ps
`default_nettype none

module tick_timer import tg_timing_pkg::*; (
   input  logic  clk,
   input  logic  clr_i,
   input  logic  load_i,
   input  tick_t count_i,   // Ticks to run
   output logic  done_o
);
   logic [3:0] prescale;  // Clocks left in current tick
   tick_t      count;     // Ticks left

   // Done lands 10N-2 clocks after the load cycle
   always_ff @(posedge clk) begin
      if (clr_i) begin
         prescale <= PRESCALE_RELOAD;
         count    <= '0;
      end else if (load_i) begin
         prescale <= PRESCALE_FIRST;
         count    <= count_i;
      end else if (count != '0) begin
         if (prescale == 4'd0) begin
            prescale <= PRESCALE_RELOAD;
            count    <= count - 1'b1;
         end else begin
            prescale <= prescale - 1'b1;
         end
      end
   end

   assign done_o = (count == '0);

endmodule

`default_nettype wire

// File: burst/burst_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module burst_sequencer import tg_timing_pkg::*; (
   input  logic      clk,
   input  logic      clr_i,
   input  logic      abt_i,
   input  logic      arm_i,
   input  logic      trig_rise_i,
   input  logic      cont_i,      // Re-arm after each burst
   input  logic      src_en_i,    // RF gate allowed
   input  count_t    np_i,        // Pulses per burst
   input  tick_t     td_i,        // Delay to first pulse
   input  tick_t     tw_i,        // Pulse width
   input  tick_t     tf_i,        // Gap between pulses
   output logic      rf_gate_o,
   output logic      pulse_start_o,
   output logic      burst_start_o,
   output logic      tdone_o,
   output tg_state_e state_o
);
   tg_state_e state;
   count_t    np_l, npulses;     // Latched count, pulses left
   tick_t     td_l, tw_l, tf_l;
   tick_t     tm_val;            // Next timer value
   logic      tm_load;
   logic      tm_done;

   tick_timer u_timer (
      .clk     (clk),
      .clr_i   (clr_i),
      .load_i  (tm_load),
      .count_i (tm_val),
      .done_o  (tm_done)
   );

   // Parameters sampled at the trigger, one burst per trigger
   always_ff @(posedge clk) begin
      if (state == Armed && trig_rise_i) begin
         np_l <= np_i;
         td_l <= td_i;
         tw_l <= tw_i;
         tf_l <= tf_i;
      end
   end

   // --------------------------------------------------
   // Burst FSM
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (clr_i || abt_i) begin
         state         <= Idle;
         rf_gate_o     <= 1'b0;
         pulse_start_o <= 1'b0;
         burst_start_o <= 1'b0;
         tdone_o       <= 1'b0;
         tm_load       <= 1'b0;
         npulses       <= '0;
      end else begin
         pulse_start_o <= 1'b0;  // Strobes last one cycle
         burst_start_o <= 1'b0;
         tdone_o       <= 1'b0;
         tm_load       <= 1'b0;
         case (state)
            Idle:
               if (arm_i) state <= Armed;
            Armed:
               if (trig_rise_i) begin
                  burst_start_o <= 1'b1;  // Meas side latches its set now
                  state         <= BurstStart;
               end
            BurstStart:
               if (np_l == '0 || tw_l == '0) begin
                  state <= BurstEnd;  // Empty burst, no pulses
               end else begin
                  npulses <= np_l;
                  tm_val  <= td_l;
                  tm_load <= 1'b1;
                  state   <= PulseOffStart;
               end
            PulseOffStart: state <= PulseOff;  // Timer takes load here
            PulseOff:
               if (tm_done) begin
                  rf_gate_o     <= src_en_i;  // Pulse runs even with gate off
                  pulse_start_o <= 1'b1;
                  tm_val        <= tw_l;
                  tm_load       <= 1'b1;
                  state         <= PulseOnStart;
               end
            PulseOnStart: begin
               npulses <= npulses - 1'b1;  // Counted at pulse start
               state   <= PulseOn;
            end
            PulseOn:
               if (tm_done) begin
                  rf_gate_o <= 1'b0;
                  if (npulses == '0) begin
                     state <= BurstEnd;
                  end else begin
                     tm_val  <= tf_l;
                     tm_load <= 1'b1;
                     state   <= PulseOffStart;
                  end
               end
            BurstEnd: begin
               tdone_o <= 1'b1;
               state   <= cont_i ? Armed : Idle;
            end
            default: state <= Idle;
         endcase
      end
   end

   assign state_o = state;

endmodule

`default_nettype wire

// File: meas/meas_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module meas_sequencer import tg_timing_pkg::*, tg_meas_pkg::*; (
   input  logic    clk,
   input  logic    clr_i,
   input  logic    abt_i,
   input  logic    arm_i,
   input  logic    conv_req_i,     // Forced conversion strobe
   input  logic    burst_start_i,
   input  logic    pulse_start_i,
   input  count_t  tc_i,           // Conversions per burst
   input  count_t  tk_i,           // Pulses skipped before the first
   input  count_t  ts_i,           // Pulses skipped between conversions
   input  tick_t   to_i,           // Offset into the pulse
   input  maxcnt_t max_count_i,    // Budget over all bursts
   output logic    conv_o
);
   meas_state_e state;
   count_t      tc_l, tk_l, ts_l;
   tick_t       to_l;
   count_t      mnpulses;   // Conversions left this burst
   count_t      mnskip;     // Pulses left to skip
   maxcnt_t     maxpulses;  // Budget left
   logic        conv_force;
   tick_t       tm_val;
   logic        tm_load;
   logic        tm_done;

   tick_timer u_timer (
      .clk     (clk),
      .clr_i   (clr_i),
      .load_i  (tm_load),
      .count_i (tm_val),
      .done_o  (tm_done)
   );

   always_ff @(posedge clk) begin
      if (burst_start_i) begin
         tc_l <= tc_i;
         tk_l <= tk_i;
         ts_l <= ts_i;
         to_l <= to_i;
      end
   end

   // --------------------------------------------------
   // Conversion scheduling
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (clr_i || abt_i) begin
         state      <= MIdle;
         conv_o     <= 1'b0;
         conv_force <= 1'b0;
         tm_load    <= 1'b0;
      end else begin
         conv_o  <= 1'b0;
         tm_load <= 1'b0;
         if (conv_req_i) conv_force <= 1'b1;  // Held until taken
         case (state)
            MIdle: begin
               maxpulses <= max_count_i;  // Fresh budget each arm
               if (arm_i)           state <= MArmed;
               else if (conv_force) state <= ConvForce;
            end
            MArmed:
               if (burst_start_i)   state <= MBurstStart;
               else if (conv_force) state <= ConvForce;
            MBurstStart:
               if (tc_l == '0) begin
                  state <= MArmed;
               end else begin
                  mnpulses <= tc_l;
                  mnskip   <= tk_l;
                  state    <= ConvWait;
               end
            ConvForce: begin
               conv_force <= 1'b0;
               maxpulses  <= maxcnt_t'(1);  // Back to idle afterwards
               mnpulses   <= count_t'(1);
               tm_val     <= tick_t'(FORCE_DELAY);
               tm_load    <= 1'b1;
               state      <= ConvDelay;
            end
            ConvWait:
               if (burst_start_i) begin
                  state <= MBurstStart;  // Next burst restarts the count
               end else if (pulse_start_i) begin
                  if (mnskip == '0) begin
                     tm_val  <= to_l;
                     tm_load <= 1'b1;
                     state   <= ConvDelay;
                  end else begin
                     mnskip <= mnskip - 1'b1;
                  end
               end
            ConvDelay: state <= ConvStart;  // Timer load settles
            ConvStart:
               if (tm_done) begin
                  conv_o    <= 1'b1;
                  mnpulses  <= mnpulses - 1'b1;
                  maxpulses <= maxpulses - 1'b1;
                  state     <= ConvEnd;
               end
            ConvEnd:
               if (maxpulses == '0) begin
                  state <= MIdle;  // Budget spent, needs re-arm
               end else if (mnpulses == '0) begin
                  state <= MArmed;
               end else begin
                  mnskip <= ts_l;
                  state  <= ConvWait;
               end
            default: state <= MIdle;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: meas/adc_capture.sv
`timescale 1ns/1ps
`default_nettype none

module adc_capture import tg_meas_pkg::*; (
   input  logic    clk,
   input  logic    clr_i,
   input  logic    conv_i,       // Start of conversion
   input  logic    adcf_sdo_i,   // Forward ADC data
   input  logic    adcr_sdo_i,   // Reverse ADC data
   output logic    adc_sck_o,
   output logic    wr_en_o,
   output sample_t wr_dat_o
);
   adc_state_e  state;
   logic [5:0]  acount;    // SCK periods left
   logic [1:0]  sck_time;  // High stretch
   logic [1:0]  widx;      // Queue word being unloaded
   logic [31:0] adcf_dat;  // Leading zero bits fall off the top
   logic [31:0] adcr_dat;

   always_ff @(posedge clk) begin
      if (clr_i) begin
         state     <= AIdle;
         adc_sck_o <= 1'b0;
         wr_en_o   <= 1'b0;
         widx      <= '0;
      end else begin
         wr_en_o <= 1'b0;
         case (state)
            AIdle:
               if (conv_i) begin
                  acount <= 6'(ADC_BITS);
                  state  <= SckOn;
               end
            SckOn: begin  // 4 high, 1 low
               adc_sck_o <= 1'b1;
               acount    <= acount - 1'b1;
               sck_time  <= 2'(SCK_STRETCH);
               state     <= SckOnWait;
            end
            SckOnWait:
               if (sck_time == '0) state <= SckOff;
               else                sck_time <= sck_time - 1'b1;
            SckOff: begin
               adc_sck_o <= 1'b0;
               adcf_dat  <= {adcf_dat[30:0], adcf_sdo_i};
               adcr_dat  <= {adcr_dat[30:0], adcr_sdo_i};
               state     <= (acount == '0) ? Unload : SckOn;
            end
            Unload: begin
               wr_en_o <= 1'b1;
               case (widx)  // 14-bit results, left aligned
                  2'd0:    wr_dat_o <= {adcf_dat[31:18], 2'b00};
                  2'd1:    wr_dat_o <= {adcf_dat[15:2], 2'b00};
                  2'd2:    wr_dat_o <= {adcr_dat[31:18], 2'b00};
                  default: wr_dat_o <= {adcr_dat[15:2], 2'b00};
               endcase
               widx <= widx + 1'b1;
               if (widx == 2'd3) state <= AIdle;
            end
            default: state <= AIdle;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: meas/meas_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module meas_fifo import tg_meas_pkg::*; #(
   parameter int MQ_AW = 8
) (
   input  logic           clk,
   input  logic           clr_i,
   input  logic           wr_en_i,
   input  sample_t        wr_dat_i,
   input  logic           rd_i,      // One cycle pop
   output sample_t        dat_o,     // Oldest word
   output logic [MQ_AW:0] count_o,
   output logic           half_o
);
   localparam logic [MQ_AW:0] DEPTH = 1 << MQ_AW;
   localparam logic [MQ_AW:0] HALF  = DEPTH >> 1;

   sample_t          mem [DEPTH];
   logic [MQ_AW-1:0] wptr, rptr;
   logic             wr, rd;

   assign wr = wr_en_i & (count_o != DEPTH);  // Full drops the write
   assign rd = rd_i & (count_o != '0);

   always_ff @(posedge clk) begin
      if (wr) mem[wptr] <= wr_dat_i;
   end

   always_ff @(posedge clk) begin
      if (clr_i) begin
         wptr    <= '0;
         rptr    <= '0;
         count_o <= '0;
         half_o  <= 1'b0;
      end else begin
         if (wr) wptr <= wptr + 1'b1;
         if (rd) rptr <= rptr + 1'b1;
         if (wr && !rd)      count_o <= count_o + 1'b1;
         else if (rd && !wr) count_o <= count_o - 1'b1;
         half_o <= (count_o >= HALF);
      end
   end

   assign dat_o = mem[rptr];

endmodule

`default_nettype wire

// File: verilog/tg_top.sv
`timescale 1ns/1ps
`default_nettype none

module tg_top import tg_timing_pkg::*, tg_meas_pkg::*; #(
   parameter int MQ_AW = 8   // Queue depth 2**MQ_AW
) (
   input  logic           clk,
   input  logic           mrst,
   input  logic [7:0]     control_i,
   input  logic           t_rst_i,
   input  logic           t_abt_i,
   input  logic           t_arm_i,
   input  logic           t_trig_i,
   input  logic           m_rst_i,
   input  logic           m_abt_i,
   input  logic           m_arm_i,
   input  logic           conv_i,
   input  count_t         np_i,
   input  tick_t          td_i,
   input  tick_t          tw_i,
   input  tick_t          tf_i,
   input  count_t         tc_i,
   input  count_t         tk_i,
   input  count_t         ts_i,
   input  tick_t          to_i,
   input  maxcnt_t        max_count_i,
   input  logic           adcf_sdo_i,
   input  logic           adcr_sdo_i,
   input  logic           mq_rd_i,
   output logic           rf_gate_o,
   output logic           adc_sck_o,
   output logic           conv_o,
   output logic           tdone_o,
   output tg_state_e      tstate_o,
   output sample_t        mq_dat_o,
   output logic [MQ_AW:0] mq_count_o,
   output logic           mhalf_o
);
   // --------------------------------------------------
   // Decoded controls and stage links
   // --------------------------------------------------
   logic t_clr, t_abt, t_arm, t_trig_rise, t_cont, src_en;
   logic m_clr, m_abt, m_arm, m_conv_req, q_clr;
   logic burst_start, pulse_start;
   logic wr_en;
   sample_t wr_dat;

   tg_ctrl_decode u_decode (
      .clk(clk), .mrst(mrst), .control_i(control_i),
      .t_rst_i(t_rst_i), .t_abt_i(t_abt_i), .t_arm_i(t_arm_i), .t_trig_i(t_trig_i),
      .m_rst_i(m_rst_i), .m_abt_i(m_abt_i), .m_arm_i(m_arm_i), .conv_i(conv_i),
      .t_clr_o(t_clr), .t_abt_o(t_abt), .t_arm_o(t_arm), .t_trig_rise_o(t_trig_rise),
      .t_cont_o(t_cont), .src_en_o(src_en), .m_clr_o(m_clr), .m_abt_o(m_abt),
      .m_arm_o(m_arm), .m_conv_req_o(m_conv_req), .q_clr_o(q_clr)
   );

   burst_sequencer u_burst (
      .clk(clk), .clr_i(t_clr), .abt_i(t_abt), .arm_i(t_arm), .trig_rise_i(t_trig_rise),
      .cont_i(t_cont), .src_en_i(src_en), .np_i(np_i), .td_i(td_i), .tw_i(tw_i),
      .tf_i(tf_i), .rf_gate_o(rf_gate_o), .pulse_start_o(pulse_start),
      .burst_start_o(burst_start), .tdone_o(tdone_o), .state_o(tstate_o)
   );

   meas_sequencer u_meas (
      .clk(clk), .clr_i(m_clr), .abt_i(m_abt), .arm_i(m_arm), .conv_req_i(m_conv_req),
      .burst_start_i(burst_start), .pulse_start_i(pulse_start), .tc_i(tc_i),
      .tk_i(tk_i), .ts_i(ts_i), .to_i(to_i), .max_count_i(max_count_i), .conv_o(conv_o)
   );

   adc_capture u_adc (
      .clk(clk), .clr_i(m_clr), .conv_i(conv_o), .adcf_sdo_i(adcf_sdo_i),
      .adcr_sdo_i(adcr_sdo_i), .adc_sck_o(adc_sck_o), .wr_en_o(wr_en), .wr_dat_o(wr_dat)
   );

   meas_fifo #(.MQ_AW(MQ_AW)) u_mq (
      .clk(clk), .clr_i(q_clr), .wr_en_i(wr_en), .wr_dat_i(wr_dat), .rd_i(mq_rd_i),
      .dat_o(mq_dat_o), .count_o(mq_count_o), .half_o(mhalf_o)
   );

endmodule

`default_nettype wire

// File: bench/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
   input  logic        clk,
   input  logic        rf_gate_i,
   input  logic        conv_i,
   input  logic        tdone_i,
   input  logic [3:0]  tstate_i,
   input  logic        adc_sck_i,
   input  logic        mq_rd_i,
   input  logic [15:0] mq_dat_i,
   input  logic [8:0]  mq_count_i,
   input  logic        mhalf_i
);
   localparam int SCK_PER_CONV = 35;   // 3 leading zeros plus 32 frame bits
   localparam int QUEUE_HALF   = 128;  // Half of the 256 word queue

   string       test_name;
   bit          active;
   bit          check_width;     // Off for aborted bursts
   int          exp_gates, exp_convs, exp_tdone, tw_ticks;
   int          gates, convs, tdones, hi_len, sck_falls;
   logic        gate_q;
   logic        sck_q;
   logic [15:0] exp_words[$];    // Built from the ADC model frames
   int          errors, test_errors, tests_run, tests_failed;

   initial begin
      active       = 0;
      gate_q       = 1'b0;
      sck_q        = 1'b0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
   end

   task automatic start_test(input string name, input int n_gates, input int tw,
                             input int n_convs, input int n_tdone, input bit width_chk);
      test_name   = name;
      exp_gates   = n_gates;
      tw_ticks    = tw;
      exp_convs   = n_convs;
      exp_tdone   = n_tdone;
      check_width = width_chk;
      gates       = 0;
      convs       = 0;
      tdones      = 0;
      hi_len      = 0;
      sck_falls   = 0;
      test_errors = 0;
      exp_words.delete();
      active      = 1;
   endtask

   task automatic fail(input string msg);
      $display("%s", msg);
      test_errors++;
   endtask

   // Four words per frame: fwd high, fwd low, rev high, rev low, 14 bits left aligned
   task automatic add_frame(input logic [31:0] fwd, input logic [31:0] rev);
      exp_words.push_back({fwd[31:18], 2'b00});
      exp_words.push_back({fwd[15:2], 2'b00});
      exp_words.push_back({rev[31:18], 2'b00});
      exp_words.push_back({rev[15:2], 2'b00});
   endtask

   // --------------------------------------------------
   // Sampled at posedge, before the DUT updates
   // --------------------------------------------------
   always @(posedge clk) begin
      if (active) begin
         if (rf_gate_i) hi_len++;
         if (rf_gate_i && !gate_q) gates++;         // Rising gate
         if (!rf_gate_i && gate_q && check_width) begin
            if (hi_len < 10 * tw_ticks || hi_len > 10 * tw_ticks + 2)
               fail($sformatf("mismatch %s gate width: expected %0d..%0d actual %0d",
                    test_name, 10 * tw_ticks, 10 * tw_ticks + 2, hi_len));
         end
         if (!rf_gate_i) hi_len = 0;
         if (conv_i)  convs++;
         if (tdone_i) tdones++;
         if (sck_q && !adc_sck_i) sck_falls++;      // Falling SCK step
         if (mq_rd_i) begin
            // Level and flag settle between pops, queue holds what is still expected
            if (mq_count_i != exp_words.size())
               fail($sformatf("mismatch %s queue level: expected %0d actual %0d",
                    test_name, exp_words.size(), mq_count_i));
            if (mhalf_i !== (exp_words.size() >= QUEUE_HALF))
               fail($sformatf("mismatch %s half flag: expected %0d actual %0d",
                    test_name, exp_words.size() >= QUEUE_HALF, mhalf_i));
            if (exp_words.size() == 0)
               fail($sformatf("%s: queue gave a word that no conversion produced", test_name));
            else if (mq_dat_i !== exp_words[0])
               fail($sformatf("mismatch %s queue word: expected %h actual %h",
                    test_name, exp_words[0], mq_dat_i));
            if (exp_words.size() != 0) void'(exp_words.pop_front());
         end
      end
      gate_q <= rf_gate_i;
      sck_q  <= adc_sck_i;
   end

   task automatic finish_test(input bit after_abort);
      active = 0;
      if (gates != exp_gates)
         fail($sformatf("mismatch %s gate pulses: expected %0d actual %0d",
              test_name, exp_gates, gates));
      if (convs != exp_convs)
         fail($sformatf("mismatch %s conversions: expected %0d actual %0d",
              test_name, exp_convs, convs));
      if (sck_falls != SCK_PER_CONV * exp_convs)
         fail($sformatf("mismatch %s SCK periods: expected %0d actual %0d",
              test_name, SCK_PER_CONV * exp_convs, sck_falls));
      if (tdones != exp_tdone)
         fail($sformatf("mismatch %s tdone pulses: expected %0d actual %0d",
              test_name, exp_tdone, tdones));
      if (exp_words.size() != 0)
         fail($sformatf("%s: %0d queue words never came out", test_name, exp_words.size()));
      if (after_abort && rf_gate_i)
         fail($sformatf("%s: RF gate still high after abort", test_name));
      if (after_abort && tstate_i != 4'd0)
         fail($sformatf("%s: burst state did not return to Idle after abort", test_name));
      tests_run++;
      if (test_errors != 0) tests_failed++;
      errors += test_errors;
      $display("test %s: %0d error(s)", test_name, test_errors);
   endtask

endmodule

`default_nettype wire

// File: bench/tb_tg.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tg;

   typedef struct {
      string name;
      logic [7:0] ctrl;
      int np, td, tw, tf, tc, tk, ts, to, maxc, trigs;
      bit force_conv, abort;
   } row_t;

   localparam int N_ROWS = 8;

   logic clk, mrst;
   logic [7:0] control_i;
   logic t_rst_i, t_abt_i, t_arm_i, t_trig_i, m_rst_i, m_abt_i, m_arm_i, conv_req;
   logic [11:0] np_i, tc_i, tk_i, ts_i;
   logic [14:0] td_i, tw_i, tf_i, to_i;
   logic [10:0] max_count_i;
   logic adcf_sdo_i, adcr_sdo_i, mq_rd_i;
   logic rf_gate_o, adc_sck_o, conv_o, tdone_o, mhalf_o;
   logic [3:0] tstate_o;
   logic [15:0] mq_dat_o;
   logic [8:0] mq_count_o;

   row_t rows[N_ROWS];
   int   cycles, limit, quiet;
   logic [31:0] lfsr, fwd_frame, rev_frame;
   int   bit_idx;
   logic sck_q;

   tg_top #(.MQ_AW(8)) UUT (
      .clk(clk), .mrst(mrst), .control_i(control_i), .t_rst_i(t_rst_i), .t_abt_i(t_abt_i),
      .t_arm_i(t_arm_i), .t_trig_i(t_trig_i), .m_rst_i(m_rst_i), .m_abt_i(m_abt_i),
      .m_arm_i(m_arm_i), .conv_i(conv_req), .np_i(np_i), .td_i(td_i), .tw_i(tw_i),
      .tf_i(tf_i), .tc_i(tc_i), .tk_i(tk_i), .ts_i(ts_i), .to_i(to_i),
      .max_count_i(max_count_i), .adcf_sdo_i(adcf_sdo_i), .adcr_sdo_i(adcr_sdo_i),
      .mq_rd_i(mq_rd_i), .rf_gate_o(rf_gate_o), .adc_sck_o(adc_sck_o), .conv_o(conv_o),
      .tdone_o(tdone_o), .tstate_o(tstate_o), .mq_dat_o(mq_dat_o),
      .mq_count_o(mq_count_o), .mhalf_o(mhalf_o)
   );

   tb_checker u_check (
      .clk(clk), .rf_gate_i(rf_gate_o), .conv_i(conv_o), .tdone_i(tdone_o),
      .tstate_i(tstate_o), .adc_sck_i(adc_sck_o), .mq_rd_i(mq_rd_i), .mq_dat_i(mq_dat_o),
      .mq_count_i(mq_count_o), .mhalf_i(mhalf_o)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;  // 40 ns period
   end

   // Galois LFSR, taps 32,22,2,1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
   endfunction

   // --------------------------------------------------
   // ADC model: 3 zero bits then 32 frame bits, MSB first
   // --------------------------------------------------
   always @(negedge clk) begin
      if (conv_o) begin
         for (int i = 0; i < 64; i++) begin
            lfsr = lfsr_next(lfsr);
            if (i < 32) fwd_frame = {fwd_frame[30:0], lfsr[0]};
            else        rev_frame = {rev_frame[30:0], lfsr[0]};
         end
         u_check.add_frame(fwd_frame, rev_frame);
         bit_idx = 0;
      end else if (sck_q && !adc_sck_o) begin
         bit_idx++;  // Next bit after each SCK fall
      end
      sck_q = adc_sck_o;
      adcf_sdo_i = (bit_idx >= 3 && bit_idx < 35) ? fwd_frame[34 - bit_idx] : 1'b0;
      adcr_sdo_i = (bit_idx >= 3 && bit_idx < 35) ? rev_frame[34 - bit_idx] : 1'b0;
   end

   // Pulses tk, tk+ts+1, ... below np, at most tc of them
   function automatic int conv_rule(input row_t r);
      int n;
      n = 0;
      if (r.tw == 0) return 0;
      for (int p = r.tk; p < r.np && n < r.tc; p += r.ts + 1) n++;
      return n;
   endfunction

   task automatic add_row(input int i, input string name, input logic [7:0] ctrl,
                          input int np, input int tc, input int tk, input int ts,
                          input int maxc, input int trigs, input bit fc, input bit ab);
      rows[i] = '{name: name, ctrl: ctrl, np: np, td: 5, tw: 8, tf: 15, tc: tc, tk: tk,
                  ts: ts, to: 2, maxc: maxc, trigs: trigs, force_conv: fc, abort: ab};
   endtask

   task automatic wait_quiet;  // ADC idle long enough that no frame is pending
      quiet = 0;
      while (quiet < 250) begin
         @(negedge clk);
         quiet = (adc_sck_o || conv_o) ? 0 : quiet + 1;
      end
   endtask

   always @(posedge clk) begin
      cycles++;
      if (cycles > limit) begin
         $display("run stopped: no progress within %0d cycles", limit);
         $display("Checks failed");
         $finish;
      end
   end

   initial begin
      int n_conv, n_gate;
      lfsr = 32'hbb51;
      cycles = 0;
      bit_idx = 40;
      sck_q = 1'b0;
      fwd_frame = '0;
      rev_frame = '0;
      mrst = 1'b1;
      control_i = 8'h00;
      conv_req = 1'b0;
      mq_rd_i = 1'b0;
      t_rst_i = 1'b0;
      t_abt_i = 1'b0;
      t_arm_i = 1'b0;
      t_trig_i = 1'b0;
      m_rst_i = 1'b0;
      m_abt_i = 1'b0;
      m_arm_i = 1'b0;
      np_i = '0;
      tc_i = '0;
      tk_i = '0;
      ts_i = '0;
      td_i = '0;
      tw_i = '0;
      tf_i = '0;
      to_i = '0;
      max_count_i = '0;
      adcf_sdo_i = 1'b0;
      adcr_sdo_i = 1'b0;
      //        name         ctrl   np tc tk ts maxc trg force abort
      add_row(0, "basic",    8'h0D, 4, 4, 0, 0, 2000, 1, 0, 0);
      add_row(1, "src_off",  8'h09, 3, 5, 1, 0, 2000, 1, 0, 0);
      add_row(2, "np_zero",  8'h0D, 0, 3, 0, 0, 2000, 1, 0, 0);
      add_row(3, "skip_cap", 8'h0D, 8, 2, 1, 2, 2000, 1, 0, 0);
      add_row(4, "max_cont", 8'h0F, 3, 3, 0, 0, 2,    2, 0, 0);
      add_row(5, "force",    8'h0D, 0, 0, 0, 0, 2000, 0, 1, 0);
      add_row(6, "abort",    8'h0D, 5, 1, 10, 0, 2000, 1, 0, 1);
      add_row(7, "half_full", 8'h0D, 40, 40, 0, 0, 2000, 1, 0, 0);  // 160 words, past half
      limit = 100;
      foreach (rows[i])
         limit += (rows[i].trigs + 1) * (10 * (rows[i].td + rows[i].np *
                  (rows[i].tw + rows[i].tf)) + 1500) + 500;
      repeat (16) @(negedge clk);
      mrst = 1'b0;
      foreach (rows[i]) begin
         control_i = rows[i].ctrl;  // Hard reset of both sides first
         t_rst_i = 1'b1;
         m_rst_i = 1'b1;
         @(negedge clk);
         t_rst_i = 1'b0;
         m_rst_i = 1'b0;
         repeat (3) @(negedge clk);
         np_i = 12'(rows[i].np);
         tc_i = 12'(rows[i].tc);
         tk_i = 12'(rows[i].tk);
         ts_i = 12'(rows[i].ts);
         td_i = 15'(rows[i].td);
         tw_i = 15'(rows[i].tw);
         tf_i = 15'(rows[i].tf);
         to_i = 15'(rows[i].to);
         max_count_i = 11'(rows[i].maxc);
         n_conv = 0;
         for (int t = 0; t < rows[i].trigs; t++) n_conv += conv_rule(rows[i]);
         if (n_conv > rows[i].maxc) n_conv = rows[i].maxc;
         n_gate = (rows[i].ctrl[2] && rows[i].tw != 0) ? rows[i].np * rows[i].trigs : 0;
         if (rows[i].force_conv) n_conv = 1;
         if (rows[i].abort) n_gate = 1;  // Only the pulse cut short
         u_check.start_test(rows[i].name, n_gate, rows[i].tw, n_conv,
                            rows[i].abort ? 0 : rows[i].trigs, !rows[i].abort);
         if (rows[i].force_conv) begin
            conv_req = 1'b1;
            @(negedge clk);
            conv_req = 1'b0;
            while (!conv_o) @(negedge clk);
            wait_quiet();
         end else begin
            t_arm_i = 1'b1;
            m_arm_i = 1'b1;
            @(negedge clk);
            t_arm_i = 1'b0;
            m_arm_i = 1'b0;
            repeat (3) @(negedge clk);
            for (int t = 0; t < rows[i].trigs; t++) begin
               t_trig_i = 1'b1;
               @(negedge clk);
               t_trig_i = 1'b0;
               if (rows[i].abort) begin
                  while (!rf_gate_o) @(negedge clk);
                  repeat (20) @(negedge clk);  // Well inside the pulse
                  t_abt_i = 1'b1;
                  @(negedge clk);
                  t_abt_i = 1'b0;
                  repeat (4) @(negedge clk);  // Decode plus FSM step
               end else begin
                  while (!tdone_o) @(negedge clk);
                  wait_quiet();
               end
            end
         end
         while (mq_count_o != '0) begin  // Drain, one pop per two cycles
            mq_rd_i = 1'b1;
            @(negedge clk);
            mq_rd_i = 1'b0;
            @(negedge clk);
         end
         @(negedge clk);
         u_check.finish_test(rows[i].abort);
      end
      $display("tests %0d, failed %0d, errors %0d",
               u_check.tests_run, u_check.tests_failed, u_check.errors);
      if (u_check.errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
common/tg_timing_pkg.sv
common/tg_meas_pkg.sv
verilog/tg_ctrl_decode.sv
verilog/tick_timer.sv
burst/burst_sequencer.sv
meas/meas_sequencer.sv
meas/adc_capture.sv
meas/meas_fifo.sv
verilog/tg_top.sv
bench/tb_checker.sv
bench/tb_tg.sv

// File: run.sh
#!/bin/bash
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_tg -o tb_tg

out=$(./obj_dir/tb_tg)
echo "$out"

if grep -qx "All checks passed" <<< "$out"; then
   exit 0
else
   exit 1
fi
